// ==== aes_valu_defs.svh ====
`ifndef AES_VALU_DEFS_SVH
`define AES_VALU_DEFS_SVH

//////////////////////////////
// State geometry
//////////////////////////////

`define AES_BYTE_W          8        // One state byte
`define AES_WORD_W          32       // One state row, four bytes
`define AES_STATE_W         128      // Full state, four rows

//////////////////////////////
// Opcodes
//////////////////////////////

`define AES_OP_W            5        // Opcode width
`define AES_OP_NOP          5'b00000 // Zero result
`define AES_OP_ADD_KEY      5'b10011 // State XOR round key
`define AES_OP_SHIFT_ROWS   5'b10100 // Row r rotated left by r bytes
`define AES_OP_MIX_COLUMNS  5'b10101 // GF(2^8) column mix

//////////////////////////////
// GF(2^8) arithmetic
//////////////////////////////

// Low byte of x^8 + x^4 + x^3 + x + 1
`define AES_XTIME_POLY      8'h1b

`endif

// ==== aes_valu_pkg.sv ====
`default_nettype none

`include "aes_valu_defs.svh"

package aes_valu_pkg;

	//////////////////////////////
	// Basic state types
	//////////////////////////////

	// One byte of the state matrix
	typedef logic [`AES_BYTE_W-1:0] aes_byte_t;

	// Four rows of four bytes
	// Row r sits at bits 32r+31:32r, column c is byte c of that row
	typedef aes_byte_t [`AES_STATE_W/`AES_WORD_W-1:0][`AES_WORD_W/`AES_BYTE_W-1:0]
		aes_state_t; // Index as [row][col]

	// Vector ALU opcode
	typedef logic [`AES_OP_W-1:0] aes_op_t;

	//////////////////////////////
	// Unit results
	//////////////////////////////

	// ShiftRows and AddRoundKey leave the same unit together
	typedef struct packed {
		aes_state_t shifted; // ShiftRows of operand A
		aes_state_t keyed;   // Operand A XOR round key
	} shift_key_res_t;

endpackage : aes_valu_pkg

`default_nettype wire

// ==== aes_mix_columns_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_valu_defs.svh"

// Standard AES MixColumns on all four columns in parallel
// Each column is multiplied by the circulant matrix 02 03 01 01
module aes_mix_columns_unit (
	input wire aes_valu_pkg::aes_state_t state, // Operand A
	output wire aes_valu_pkg::aes_state_t mixed // Column-mixed state
);

	//////////////////////////////
	// GF(2^8) helpers
	//////////////////////////////

	// Multiply by 2 modulo the AES polynomial
	function automatic aes_valu_pkg::aes_byte_t xtime(
		input aes_valu_pkg::aes_byte_t b // Byte to double
	);
		aes_valu_pkg::aes_byte_t shl; // Plain left shift
		shl = {b[`AES_BYTE_W-2:0], 1'b0};
		if (b[`AES_BYTE_W-1]) begin // Carry out of bit 7
			shl = shl ^ `AES_XTIME_POLY; // Fold x^8 back in
		end
		return shl;
	endfunction

	//////////////////////////////
	// Column mix
	//////////////////////////////

	// Output byte r of a column:
	// 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3], row indices mod 4
	// 3*a is written as 2*a ^ a, so only doubled bytes are needed
	for (genvar c = 0; c < `AES_WORD_W/`AES_BYTE_W; c++) begin : g_col
		wire aes_valu_pkg::aes_byte_t [`AES_STATE_W/`AES_WORD_W-1:0] col; // Input column c
		wire aes_valu_pkg::aes_byte_t [`AES_STATE_W/`AES_WORD_W-1:0] dbl; // 2*col per row

		for (genvar r = 0; r < `AES_STATE_W/`AES_WORD_W; r++) begin : g_row
			assign col[r] = state[r][c]; // Row r of column c
			assign dbl[r] = xtime(col[r]); // One doubling per input byte

			// Rows wrap around the 4-byte column
			assign mixed[r][c] = dbl[r]              // 2*a[r]
				^ dbl[(r + 1) % 4] ^ col[(r + 1) % 4]  // 3*a[r+1]
				^ col[(r + 2) % 4]                   // a[r+2]
				^ col[(r + 3) % 4];                  // a[r+3]
		end
	end

endmodule : aes_mix_columns_unit

`default_nettype wire

// ==== aes_shift_key_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_valu_defs.svh"

// ShiftRows and AddRoundKey side by side
// Both results are always present, the selector picks one
module aes_shift_key_unit (
	input wire aes_valu_pkg::aes_state_t state,     // Operand A
	input wire aes_valu_pkg::aes_state_t round_key, // Operand B
	output aes_valu_pkg::shift_key_res_t res        // Shifted and keyed states
);

	aes_valu_pkg::aes_state_t shifted; // ShiftRows of A
	aes_valu_pkg::aes_state_t keyed;   // A XOR B

	//////////////////////////////
	// ShiftRows
	//////////////////////////////

	// Row r rotates left by r byte positions
	// Output column c takes input column (c + r) mod 4
	always_comb begin
		for (int r = 0; r < `AES_STATE_W/`AES_WORD_W; r++) begin
			for (int c = 0; c < `AES_WORD_W/`AES_BYTE_W; c++) begin
				shifted[r][c] = state[r][(c + r) % 4]; // Row 0 passes straight
			end
		end
	end

	//////////////////////////////
	// AddRoundKey
	//////////////////////////////

	// Bytewise XOR, no movement between positions
	always_comb begin
		for (int r = 0; r < `AES_STATE_W/`AES_WORD_W; r++) begin
			for (int c = 0; c < `AES_WORD_W/`AES_BYTE_W; c++) begin
				keyed[r][c] = state[r][c] ^ round_key[r][c]; // Same row and column
			end
		end
	end

	// Pack both for the selector
	assign res.shifted = shifted;
	assign res.keyed   = keyed;

endmodule : aes_shift_key_unit

`default_nettype wire

// ==== aes_result_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_valu_defs.svh"

// Opcode decode, result mux and the output register
// Latency from op and operands to result is one clock
module aes_result_select (
	input wire clk,                                   // Core clock
	input wire rst_n,                                 // Sync reset, active low
	input wire aes_valu_pkg::aes_op_t op,             // Vector ALU opcode
	input wire aes_valu_pkg::aes_state_t mixed,       // From MixColumns unit
	input wire aes_valu_pkg::shift_key_res_t shift_key, // From ShiftRows/AddRoundKey unit
	output aes_valu_pkg::aes_state_t result           // Registered result
);

	logic sel_key;   // AddRoundKey selected
	logic sel_shift; // ShiftRows selected
	logic sel_mix;   // MixColumns selected
	aes_valu_pkg::aes_state_t result_d; // Next result

	//////////////////////////////
	// Opcode decode
	//////////////////////////////

	always_comb begin
		sel_key   = 1'b0;
		sel_shift = 1'b0;
		sel_mix   = 1'b0;
		case (op)
			`AES_OP_ADD_KEY:     sel_key   = 1'b1;
			`AES_OP_SHIFT_ROWS:  sel_shift = 1'b1;
			`AES_OP_MIX_COLUMNS: sel_mix   = 1'b1;
			default:             ;                // NOP and undefined codes select nothing
		endcase
	end

	//////////////////////////////
	// Result mux
	//////////////////////////////

	always_comb begin
		if (sel_key) begin
			result_d = shift_key.keyed;   // State XOR key
		end else if (sel_shift) begin
			result_d = shift_key.shifted; // Rows rotated
		end else if (sel_mix) begin
			result_d = mixed;             // Columns mixed
		end else begin
			result_d = '0;                // NOP or unknown
		end
	end

	// Output register, cleared while in reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else begin
			result <= result_d; // New op every cycle
		end
	end

endmodule : aes_result_select

`default_nettype wire

// ==== aes_valu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Vector ALU for AES state operations
// AddRoundKey, ShiftRows and MixColumns on a 128-bit state
module aes_valu_top (
	input wire clk,                             // Core clock
	input wire rst_n,                           // Sync reset, active low
	input wire aes_valu_pkg::aes_op_t op,       // Operation code
	input wire aes_valu_pkg::aes_state_t src_a, // State operand
	input wire aes_valu_pkg::aes_state_t src_b, // Round key
	output aes_valu_pkg::aes_state_t result     // Result, one cycle after op
);

	wire aes_valu_pkg::aes_state_t mixed;         // MixColumns of src_a
	wire aes_valu_pkg::shift_key_res_t shift_key; // ShiftRows and AddRoundKey

	//////////////////////////////
	// Datapath units
	//////////////////////////////

	aes_mix_columns_unit i_mix_columns (
		.state (src_a),
		.mixed (mixed)
	);

	aes_shift_key_unit i_shift_key (
		.state     (src_a),
		.round_key (src_b), // Key only feeds AddRoundKey
		.res       (shift_key)
	);

	//////////////////////////////
	// Select and register
	//////////////////////////////

	aes_result_select i_result_select (
		.clk       (clk),
		.rst_n     (rst_n),
		.op        (op),
		.mixed     (mixed),
		.shift_key (shift_key),
		.result    (result)
	);

endmodule : aes_valu_top

`default_nettype wire

// ==== aes_valu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_valu_defs.svh"

// Result checker for aes_valu_top, bound to its ports
// Reference values come from a separate byte model, one cycle behind the inputs
module aes_valu_props (
	input wire clk,                             // Core clock
	input wire rst_n,                           // Sync reset, active low
	input wire aes_valu_pkg::aes_op_t op,       // Opcode at the DUT port
	input wire aes_valu_pkg::aes_state_t src_a, // State operand
	input wire aes_valu_pkg::aes_state_t src_b, // Round key
	input wire aes_valu_pkg::aes_state_t result // Registered DUT result
);

	int fail_count = 0; // Read hierarchically by the testbench

	aes_valu_pkg::aes_state_t exp_key_q;   // A ^ B from the previous edge
	aes_valu_pkg::aes_state_t exp_shift_q; // Rotated rows from the previous edge
	aes_valu_pkg::aes_state_t exp_mix_q;   // Mixed columns from the previous edge

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Doubling in GF(2^8), reduction applied by mask
	function automatic aes_valu_pkg::aes_byte_t gf_double(input aes_valu_pkg::aes_byte_t b);
		return {b[6:0], 1'b0} ^ ({8{b[7]}} & `AES_XTIME_POLY);
	endfunction

	// Byte c holds column c, so a left rotate of the row is a right shift of the word
	function automatic aes_valu_pkg::aes_state_t rotate_rows(input aes_valu_pkg::aes_state_t s);
		aes_valu_pkg::aes_state_t o; // Rotated state
		logic [63:0] twice;          // Row doubled for wraparound
		for (int r = 0; r < 4; r++) begin
			twice = {s[r], s[r]} >> (8 * r); // Drop r bytes off the bottom
			o[r] = twice[31:0];
		end
		return o;
	endfunction

	// 2*a ^ 3*b == 2*(a ^ b) ^ b, so one doubling per output byte
	function automatic aes_valu_pkg::aes_state_t mix_cols(input aes_valu_pkg::aes_state_t s);
		aes_valu_pkg::aes_state_t o; // Mixed state
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				o[r][c] = gf_double(s[r][c] ^ s[(r + 1) & 3][c])
					^ s[(r + 1) & 3][c] ^ s[(r + 2) & 3][c] ^ s[(r + 3) & 3][c];
			end
		end
		return o;
	endfunction

	always_ff @(posedge clk) begin
		exp_key_q   <= src_a ^ src_b;       // AddRoundKey
		exp_shift_q <= rotate_rows(src_a); // ShiftRows
		exp_mix_q   <= mix_cols(src_a);    // MixColumns
	end

	//////////////////////////////
	// Assertions
	//////////////////////////////

	// Cleared on every edge in reset, so zero in the first cycle after it
	a_reset_clear: assert property (@(posedge clk) !rst_n |=> result == '0)
		else begin
			$error("MISMATCH reset expected 0 actual %h", $sampled(result));
			fail_count++;
		end

	a_add_key: assert property (@(posedge clk)
		rst_n && op == `AES_OP_ADD_KEY |=> result == exp_key_q)
		else begin
			$error("MISMATCH add_key expected %h actual %h",
				$sampled(exp_key_q), $sampled(result));
			fail_count++;
		end

	a_shift_rows: assert property (@(posedge clk)
		rst_n && op == `AES_OP_SHIFT_ROWS |=> result == exp_shift_q)
		else begin
			$error("MISMATCH shift_rows expected %h actual %h",
				$sampled(exp_shift_q), $sampled(result));
			fail_count++;
		end

	a_mix_columns: assert property (@(posedge clk)
		rst_n && op == `AES_OP_MIX_COLUMNS |=> result == exp_mix_q)
		else begin
			$error("MISMATCH mix_columns expected %h actual %h",
				$sampled(exp_mix_q), $sampled(result));
			fail_count++;
		end

	// NOP and every code outside the three operations
	a_zero_code: assert property (@(posedge clk)
		rst_n && !(op inside {`AES_OP_ADD_KEY, `AES_OP_SHIFT_ROWS, `AES_OP_MIX_COLUMNS})
		|=> result == '0)
		else begin
			$error("MISMATCH zero_code expected 0 actual %h", $sampled(result));
			fail_count++;
		end

endmodule : aes_valu_props

bind aes_valu_top aes_valu_props i_props (.*);

`default_nettype wire

// ==== aes_valu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_valu_defs.svh"

module aes_valu_tb;

	localparam int          CLK_HALF     = 4;             // 8 ns period
	localparam int          RESET_CYCLES = 5;             // rst_n low this long
	localparam int          WAIT_LIMIT   = 50;            // Cycles before a wait gives up
	localparam int          RAND_OPS     = 24;            // Random operations per test
	localparam logic [31:0] SEED         = 32'h44a7d158;

	logic clk;
	logic rst_n;
	aes_valu_pkg::aes_op_t op;
	aes_valu_pkg::aes_state_t src_a;
	aes_valu_pkg::aes_state_t src_b;
	aes_valu_pkg::aes_state_t result;

	int tb_errors;      // Failed direct compares in this module
	int tests_passed;
	int tests_failed;
	int fails_at_start; // Failure total when the current test began

	aes_valu_top i_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.op     (op),
		.src_a  (src_a),
		.src_b  (src_b),
		.result (result)
	);

	//////////////////////////////
	// Clock and reset
	//////////////////////////////

	initial begin
		clk = 1'b0;
		forever begin
			#CLK_HALF clk = ~clk;
		end
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1; // Released on a falling edge like every input
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Assertion failures plus direct compare failures
	function automatic int total_fails();
		return i_dut.i_props.fail_count + tb_errors;
	endfunction

	function automatic aes_valu_pkg::aes_state_t random_state();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	function automatic aes_valu_pkg::aes_op_t random_defined_op();
		aes_valu_pkg::aes_op_t code; // One of the three operations
		case ($urandom_range(2))
			0:       code = `AES_OP_ADD_KEY;
			1:       code = `AES_OP_SHIFT_ROWS;
			default: code = `AES_OP_MIX_COLUMNS;
		endcase
		return code;
	endfunction

	function automatic aes_valu_pkg::aes_op_t random_undefined_op();
		aes_valu_pkg::aes_op_t code; // Anything but the three operations
		do begin
			code = 5'($urandom_range(31));
		end while (code == `AES_OP_ADD_KEY || code == `AES_OP_SHIFT_ROWS
			|| code == `AES_OP_MIX_COLUMNS);
		return code;
	endfunction

	// Inputs change on the falling edge, the DUT samples on the next rising one
	task automatic drive(input aes_valu_pkg::aes_op_t code,
		input aes_valu_pkg::aes_state_t a, input aes_valu_pkg::aes_state_t b);
		@(negedge clk);
		op    = code;
		src_a = a;
		src_b = b;
	endtask

	task automatic start_test();
		fails_at_start = total_fails();
	endtask

	// Two NOP cycles so the last operation has been checked
	task automatic end_test(input string name);
		int new_fails; // Failures seen during this test
		drive(`AES_OP_NOP, '0, '0);
		drive(`AES_OP_NOP, '0, '0);
		new_fails = total_fails() - fails_at_start;
		if (new_fails == 0) begin
			tests_passed++;
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: %0d failures", name, new_fails);
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic run_add_key();
		start_test();
		for (int i = 0; i < RAND_OPS; i++) begin
			drive(`AES_OP_ADD_KEY, random_state(), random_state()); // Checked by a_add_key
		end
		end_test("add_key");
	endtask

	task automatic run_shift_rows();
		start_test();
		for (int i = 0; i < RAND_OPS; i++) begin
			drive(`AES_OP_SHIFT_ROWS, random_state(), random_state()); // Key is ignored
		end
		end_test("shift_rows");
	endtask

	task automatic run_mix_columns();
		aes_valu_pkg::aes_byte_t col_in [4];  // Known column, top row first
		aes_valu_pkg::aes_byte_t col_out [4]; // Its published MixColumns image
		aes_valu_pkg::aes_state_t a;
		aes_valu_pkg::aes_state_t expected;
		col_in  = '{8'hdb, 8'h13, 8'h53, 8'h45};
		col_out = '{8'h8e, 8'h4d, 8'ha1, 8'hbc};
		start_test();
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				a[r][c]        = col_in[r];  // Same column in all four places
				expected[r][c] = col_out[r];
			end
		end
		drive(`AES_OP_MIX_COLUMNS, a, '0);
		@(negedge clk); // Result is one edge behind
		if (result !== expected) begin
			$display("MISMATCH mix_columns expected %h actual %h", expected, result);
			tb_errors++;
		end
		for (int i = 0; i < RAND_OPS; i++) begin
			drive(`AES_OP_MIX_COLUMNS, random_state(), random_state());
		end
		end_test("mix_columns");
	endtask

	task automatic run_zero_codes();
		aes_valu_pkg::aes_op_t fixed_codes [5]; // NOP and codes near the defined ones
		fixed_codes = '{`AES_OP_NOP, 5'b10001, 5'b10010, 5'b10110, 5'b11111};
		start_test();
		foreach (fixed_codes[i]) begin
			drive(fixed_codes[i], random_state(), random_state());
		end
		for (int i = 0; i < RAND_OPS; i++) begin
			drive(random_undefined_op(), random_state(), random_state());
		end
		end_test("zero_codes");
	endtask

	// Opcode and operands change every cycle, one in four is undefined
	task automatic run_back_to_back();
		aes_valu_pkg::aes_op_t code;
		start_test();
		for (int i = 0; i < 2 * RAND_OPS; i++) begin
			if ($urandom_range(3) == 3) begin
				code = random_undefined_op();
			end else begin
				code = random_defined_op();
			end
			drive(code, random_state(), random_state());
		end
		end_test("back_to_back");
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int   waited;   // Cycles spent waiting for reset release
		logic rst_seen; // rst_n high at a rising edge
		void'($urandom(SEED));
		op             = `AES_OP_NOP;
		src_a          = '0;
		src_b          = '0;
		tb_errors      = 0;
		tests_passed   = 0;
		tests_failed   = 0;
		fails_at_start = 0;
		waited         = 0;
		rst_seen       = 1'b0;

		// Busy operations during reset must not reach the result
		while (!rst_seen && waited <= WAIT_LIMIT) begin
			@(negedge clk);
			if (result !== '0) begin
				$display("MISMATCH reset expected %h actual %h", 128'h0, result);
				tb_errors++;
			end
			op    = random_defined_op();
			src_a = random_state();
			src_b = random_state();
			@(posedge clk);
			rst_seen = rst_n;
			waited++;
		end

		if (!rst_seen) begin
			$display("Timeout: reset was not released within %0d cycles", WAIT_LIMIT);
			$display("*** TEST FAILED ***");
		end else begin
			end_test("reset");
			run_add_key();
			run_shift_rows();
			run_mix_columns();
			run_zero_codes();
			run_back_to_back();
			$display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
			if (tests_failed == 0 && total_fails() == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
		end
		$finish;
	end

endmodule : aes_valu_tb

`default_nettype wire

// ==== list.f ====
+incdir+.
aes_valu_pkg.sv
aes_mix_columns_unit.sv
aes_shift_key_unit.sv
aes_result_select.sv
aes_valu_top.sv
aes_valu_props.sv
aes_valu_tb.sv
